// File: bench/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_CYCLE  = 5;    // 10 ns period
    localparam int RESET_TICKS = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_CYCLE clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_TICKS) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: bench/kbd_hub_assertions.sv
`timescale 1ns/1ns
`include "kbd_defs.svh"

module kbd_hub_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  ready,
    input kbd_pkg::ascii_t       ascii,
    input logic                  overflow,
    input logic [`KBD_PORTS-1:0] frame_err
);

    // Empty FIFO never shows a character
    a_ascii_idle: assert property (@(posedge clk) disable iff (reset) !ready |-> ascii == '0)
        else $error("ascii is nonzero while ready is low");

    a_overflow_sticky: assert property (@(posedge clk) $fell(overflow) |-> $past(reset))
        else $error("overflow cleared without a reset");

    for (genvar i = 0; i < `KBD_PORTS; i++) begin : g_err
        a_err_sticky: assert property (@(posedge clk) $fell(frame_err[i]) |-> $past(reset))
            else $error("frame_err of port %0d cleared without a reset", i);
    end

    a_ready_after_reset: assert property (@(posedge clk) $past(reset) |-> !ready)
        else $error("ready is high in the cycle after reset");

endmodule

bind kbd_hub kbd_hub_assertions assertions_inst (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .ascii     (ascii),
    .overflow  (overflow),
    .frame_err (frame_err)
);

// File: bench/kbd_hub_tb.sv
`timescale 1ns/1ns
`include "kbd_defs.svh"

module kbd_hub_tb;

    localparam int PORTS       = `KBD_PORTS;
    localparam int DEPTH       = `KBD_FIFO_DEPTH;
    localparam int HALF_PERIOD = 20;                             // PS/2 half period in cycles
    localparam int WAIT_LIMIT  = 3000;
    localparam int BURST_LEN   = 6;

    // Set 2 make codes in alphabet and digit order
    localparam logic [7:0] LETTER_CODES [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
        8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam logic [7:0] DIGIT_CODES [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    logic                clk;
    logic                por_reset;
    logic                tb_reset;
    logic                reset;
    logic [PORTS-1:0]    ps2_clk;
    logic [PORTS-1:0]    ps2_data;
    logic                next;
    logic                ready;
    kbd_pkg::scan_code_t data;
    kbd_pkg::port_id_t   port;
    kbd_pkg::ascii_t     ascii;
    logic                overflow;
    logic [PORTS-1:0]    frame_err;

    logic [7:0] exp_q [PORTS][$];                                // Model, codes per port
    logic [7:0] burst_code [PORTS][BURST_LEN];
    int         burst_gap [PORTS][BURST_LEN];
    int         bursts_done;
    int         error_count;
    int         seed;

    assign reset = por_reset | tb_reset;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .reset (por_reset)
    );

    kbd_hub kbd_hub_inst (
        .clk       (clk),
        .reset     (reset),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .next      (next),
        .ready     (ready),
        .data      (data),
        .port      (port),
        .ascii     (ascii),
        .overflow  (overflow),
        .frame_err (frame_err)
    );

    function automatic logic [7:0] model_ascii(input logic [7:0] sc);
        logic [7:0] ch;
        ch = 8'h00;                                              // Unmapped codes
        for (int i = 0; i < 26; i++) begin
            if (LETTER_CODES[i] == sc) ch = 8'h41 + 8'(i);
        end
        for (int i = 0; i < 10; i++) begin
            if (DIGIT_CODES[i] == sc) ch = 8'h30 + 8'(i);
        end
        return ch;
    endfunction

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // One 11-bit frame, start bit first; bad selects 1 start, 2 parity, 3 stop
    task automatic drive_frame(input int p, input logic [7:0] code, input int bad);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        if (bad == 1) bits[0] = 1'b1;
        if (bad == 2) bits[9] = ~bits[9];
        if (bad == 3) bits[10] = 1'b0;
        @(posedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2_data[p] <= bits[i];                              // Changes while clock is high
            repeat (HALF_PERIOD / 2) @(posedge clk);
            ps2_clk[p] <= 1'b0;
            repeat (HALF_PERIOD) @(posedge clk);
            ps2_clk[p] <= 1'b1;
            repeat (HALF_PERIOD / 2) @(posedge clk);
        end
        ps2_data[p] <= 1'b1;
    endtask

    task automatic send_good(input int p, input logic [7:0] code);
        exp_q[p].push_back(code);
        drive_frame(p, code, 0);
    endtask

    task automatic send_burst(input int p);
        for (int i = 0; i < BURST_LEN; i++) begin
            repeat (burst_gap[p][i]) @(posedge clk);
            send_good(p, burst_code[p][i]);
        end
        bursts_done++;
    endtask

    task automatic wait_until(input string what, ref logic cond);
        int waited;
        waited = 0;
        @(negedge clk);
        while (cond !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout while waiting for %s", what);
                stop_on_failure();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // Matches the head entry with the queue of the port it reports
    task automatic read_one(input string name);
        int         p;
        logic [7:0] exp_code;
        wait_until({name, " ready"}, ready);
        p = int'(port);
        if (exp_q[p].size() == 0) begin
            $display("Entry from port %0d with no code expected in %s", p, name);
            stop_on_failure();
        end else begin
            exp_code = exp_q[p].pop_front();
            check_value({name, "_data"}, exp_code, data);
            check_value({name, "_ascii"}, model_ascii(exp_code), ascii);
            @(posedge clk);
            next <= 1'b1;
            @(posedge clk);
            next <= 1'b0;
        end
    endtask

    // Single read where the sending port is known
    task automatic read_port(input string name, input int exp_port);
        wait_until({name, " ready"}, ready);
        check_value({name, "_port"}, exp_port, port);
        read_one(name);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        tb_reset <= 1'b1;
        repeat (2) @(posedge clk);
        tb_reset <= 1'b0;
    endtask

    initial begin
        logic       por_done;
        logic       bursts_over;
        logic [7:0] code;
        logic [PORTS-1:0] err_mask;
        int         waited;
        seed        = 32'h7caa;
        error_count = 0;
        bursts_done = 0;
        ps2_clk  <= '1;                                          // Idle bus
        ps2_data <= '1;
        next     <= 1'b0;
        tb_reset <= 1'b0;
        waited   = 0;
        por_done = 1'b0;
        while (por_done !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout while waiting for the power-on reset to end");
                stop_on_failure();
            end else begin
                waited++;
                @(negedge clk);
                por_done = ~por_reset;
            end
        end

        // Letter, digit and unmapped code
        send_good(0, 8'h1C);
        read_port("single_letter", 0);
        send_good(1 % PORTS, 8'h45);
        read_port("single_digit", 1 % PORTS);
        send_good(0, 8'hF0);
        read_port("single_unmapped", 0);
        @(negedge clk);
        check_value("single_empty", 0, ready);

        // All ports at once with random gaps
        for (int p = 0; p < PORTS; p++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                burst_code[p][i] = 8'($random(seed));
                burst_gap[p][i]  = $random(seed) & 15;
            end
        end
        for (int p = 0; p < PORTS; p++) begin
            fork
                automatic int fp = p;
                send_burst(fp);
            join_none
        end
        for (int i = 0; i < PORTS * BURST_LEN; i++) begin
            read_one("burst");
        end
        waited      = 0;
        bursts_over = 1'b0;
        while (bursts_over !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                $display("Timeout while waiting for the burst drivers");
                stop_on_failure();
            end else begin
                waited++;
                @(negedge clk);
                bursts_over = (bursts_done == PORTS);
            end
        end
        for (int p = 0; p < PORTS; p++) begin
            check_value("burst_left", 0, exp_q[p].size());
        end
        check_value("burst_empty", 0, ready);                    // No extra entries
        check_value("burst_overflow", 0, overflow);

        // Bad frames flag only their own port
        err_mask = '0;
        for (int p = 0; p < PORTS; p++) begin
            for (int bad = 1; bad <= 3; bad++) begin
                drive_frame(p, 8'($random(seed)), bad);
                err_mask[p] = 1'b1;
                @(negedge clk);
                check_value("bad_no_entry", 0, ready);
                check_value("bad_frame_err", err_mask, frame_err);
            end
            send_good(p, 8'($random(seed)));
            read_port("after_bad", p);
        end

        // Nine frames without reading
        for (int i = 0; i < DEPTH + 1; i++) begin
            code = 8'($random(seed));
            if (i < DEPTH) begin
                send_good(i % PORTS, code);
            end else begin
                drive_frame(i % PORTS, code, 0);                 // Lost to a full FIFO
            end
        end
        @(negedge clk);
        check_value("full_ready", 1, ready);
        check_value("full_overflow", 1, overflow);
        for (int i = 0; i < DEPTH; i++) begin
            read_one("full_read");
        end
        @(negedge clk);
        check_value("full_drained", 0, ready);

        // Reset clears the flags and a waiting entry
        drive_frame(0, 8'h24, 0);
        @(negedge clk);
        check_value("pre_reset_ready", 1, ready);
        pulse_reset();
        @(negedge clk);
        check_value("reset_ready", 0, ready);
        check_value("reset_overflow", 0, overflow);
        check_value("reset_frame_err", 0, frame_err);
        send_good(PORTS - 1, 8'h3E);
        read_port("after_reset", PORTS - 1);

        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Builds the keyboard hub testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=kbd_hub_sim

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f \
        --top-module kbd_hub_tb -Mdir obj_dir -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

// File: src/kbd_defs.svh
`ifndef KBD_DEFS_SVH
`define KBD_DEFS_SVH

// Number of keyboard ports merged by the hub
`define KBD_PORTS 2

// FIFO entries, must be a power of two
`define KBD_FIFO_DEPTH 8

// Flops in front of the edge detector
`define KBD_SYNC_STAGES 2

`endif

// File: src/kbd_hub.sv
`timescale 1ns/1ns
`include "kbd_defs.svh"

module kbd_hub (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`KBD_PORTS-1:0] ps2_clk,
    input  logic [`KBD_PORTS-1:0] ps2_data,
    input  logic                  next,
    output logic                  ready,
    output kbd_pkg::scan_code_t   data,
    output kbd_pkg::port_id_t     port,
    output kbd_pkg::ascii_t       ascii,
    output logic                  overflow,
    output logic [`KBD_PORTS-1:0] frame_err
);

    ps2_rx_if rx_if [`KBD_PORTS] ();                             // One link per keyboard

    ps2_sync sync_inst (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx       (rx_if)
    );

    for (genvar i = 0; i < `KBD_PORTS; i++) begin : g_rx
        ps2_frame_rx rx_inst (
            .clk       (clk),
            .reset     (reset),
            .rx        (rx_if[i]),
            .frame_err (frame_err[i])                            // Per-port error flag
        );
    end

    scan_merge merge_inst (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx_if),
        .next     (next),
        .ready    (ready),
        .data     (data),
        .port     (port),
        .ascii    (ascii),
        .overflow (overflow)
    );

endmodule

// File: src/kbd_pkg.sv
`include "kbd_defs.svh"

package kbd_pkg;

    typedef logic [7:0] scan_code_t;                             // Raw PS/2 set 2 code
    typedef logic [7:0] ascii_t;                                 // Translated character

    // One bit for two ports
    typedef logic [$clog2(`KBD_PORTS)-1:0] port_id_t;

    typedef logic [$clog2(`KBD_FIFO_DEPTH)-1:0] fifo_ptr_t;      // Wraps naturally

    typedef enum logic [1:0] {
        RX_START,                                                // Waiting for start bit
        RX_DATA,                                                 // Eight data bits, LSB first
        RX_PARITY,                                               // Odd parity bit
        RX_STOP                                                  // Stop bit and frame check
    } rx_state_t;

endpackage

// File: src/ps2_frame_rx.sv
`timescale 1ns/1ns

module ps2_frame_rx (
    input  logic clk,
    input  logic reset,
    ps2_rx_if.rx rx,
    output logic frame_err
);

    localparam int DATA_BITS = 8;
    localparam int CNT_W     = $clog2(DATA_BITS);

    kbd_pkg::rx_state_t  state;
    logic [CNT_W-1:0]    bit_cnt;     // Data bits received so far
    logic                parity;      // Running XOR of data and parity bits
    logic                start_ok;    // Start bit was low
    kbd_pkg::scan_code_t shift_reg;
    logic                frame_good;
    logic                last_data;

    assign last_data = (bit_cnt == CNT_W'(DATA_BITS - 1));

    // Checked while the stop bit is on bit_in
    assign frame_good = start_ok & parity & rx.bit_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= kbd_pkg::RX_START;
            bit_cnt    <= '0;
            parity     <= 1'b0;
            start_ok   <= 1'b0;
            rx.pending <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            if (rx.take) begin
                rx.pending <= 1'b0;                              // Falls the cycle after take
            end
            if (rx.sample) begin
                case (state)
                    kbd_pkg::RX_START: begin
                        start_ok <= ~rx.bit_in;
                        parity   <= 1'b0;
                        bit_cnt  <= '0;
                        state    <= kbd_pkg::RX_DATA;             // Walk on even if bad
                    end
                    kbd_pkg::RX_DATA: begin
                        parity  <= parity ^ rx.bit_in;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_data) begin
                            state <= kbd_pkg::RX_PARITY;
                        end
                    end
                    kbd_pkg::RX_PARITY: begin
                        parity <= parity ^ rx.bit_in;             // Odd total leaves a 1
                        state  <= kbd_pkg::RX_STOP;
                    end
                    kbd_pkg::RX_STOP: begin
                        if (frame_good) begin
                            rx.pending <= 1'b1;                  // Wins over a same-cycle take
                        end else begin
                            frame_err <= 1'b1;                   // Sticky until reset
                        end
                        state <= kbd_pkg::RX_START;
                    end
                    default: begin
                        state <= kbd_pkg::RX_START;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.sample && state == kbd_pkg::RX_DATA) begin
            shift_reg <= {rx.bit_in, shift_reg[7:1]};            // LSB arrives first
        end
        if (rx.sample && state == kbd_pkg::RX_STOP && frame_good) begin
            rx.code <= shift_reg;
        end
    end

endmodule

// File: src/ps2_rx_if.sv
`timescale 1ns/1ns

interface ps2_rx_if;

    logic                sample;   // One-cycle strobe on PS/2 clock fall
    logic                bit_in;   // Synchronized data bit
    kbd_pkg::scan_code_t code;     // Last good frame
    logic                pending;  // Code waiting for the merger
    logic                take;     // Merger has consumed the code

    modport sync (
        output sample, bit_in
    );

    modport rx (
        input  sample, bit_in, take,
        output code, pending
    );

    modport merge (
        input  code, pending,
        output take
    );

endinterface

// File: src/ps2_sync.sv
`timescale 1ns/1ns
`include "kbd_defs.svh"

module ps2_sync (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`KBD_PORTS-1:0] ps2_clk,
    input  logic [`KBD_PORTS-1:0] ps2_data,
    ps2_rx_if.sync                rx [`KBD_PORTS]
);

    localparam int STAGES = `KBD_SYNC_STAGES;

    for (genvar i = 0; i < `KBD_PORTS; i++) begin : g_line
        logic [STAGES:0]   clk_sr;   // Sync stages plus one history flop
        logic [STAGES-1:0] data_sr;
        logic              fall;

        // High-to-low on the synchronized PS/2 clock
        assign fall = clk_sr[STAGES] & ~clk_sr[STAGES-1];

        always_ff @(posedge clk) begin
            if (reset) begin
                clk_sr       <= '1;                              // Idle high, no false edge
                data_sr      <= '1;
                rx[i].sample <= 1'b0;
            end else begin
                clk_sr       <= {clk_sr[STAGES-1:0], ps2_clk[i]};
                data_sr      <= {data_sr[STAGES-2:0], ps2_data[i]};
                rx[i].sample <= fall;
            end
        end

        // Data captured in step with the strobe
        always_ff @(posedge clk) begin
            rx[i].bit_in <= data_sr[STAGES-1];
        end
    end

endmodule

// File: src/scan_merge.sv
`timescale 1ns/1ns
`include "kbd_defs.svh"

module scan_merge (
    input  logic                clk,
    input  logic                reset,
    ps2_rx_if.merge             rx [`KBD_PORTS],
    input  logic                next,
    output logic                ready,
    output kbd_pkg::scan_code_t data,
    output kbd_pkg::port_id_t   port,
    output kbd_pkg::ascii_t     ascii,
    output logic                overflow
);

    localparam int PORTS = `KBD_PORTS;
    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic [PORTS-1:0]    pend_vec;
    kbd_pkg::scan_code_t code_vec [PORTS];
    kbd_pkg::port_id_t   last_q;      // Port served most recently
    kbd_pkg::port_id_t   grant_id;
    logic                grant_valid;

    kbd_pkg::scan_code_t mem_code [DEPTH];
    kbd_pkg::port_id_t   mem_port [DEPTH];
    kbd_pkg::fifo_ptr_t  wr_ptr;
    kbd_pkg::fifo_ptr_t  rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;
    logic                wr_en;
    logic                rd_en;

    for (genvar i = 0; i < PORTS; i++) begin : g_port
        assign pend_vec[i] = rx[i].pending;
        assign code_vec[i] = rx[i].code;
        assign rx[i].take  = grant_valid && (grant_id == kbd_pkg::port_id_t'(i));
    end

    // Search starts at the port after the last one served
    always_comb begin
        int unsigned idx;
        grant_valid = 1'b0;
        grant_id    = last_q;
        for (int k = 1; k <= PORTS; k++) begin
            idx = (int'(last_q) + k) % PORTS;
            if (!grant_valid && pend_vec[idx]) begin
                grant_valid = 1'b1;
                grant_id    = kbd_pkg::port_id_t'(idx);
            end
        end
    end

    assign full  = (count == CNT_W'(DEPTH));
    assign wr_en = grant_valid && !full;                         // Dropped when full
    assign rd_en = next && ready;
    assign ready = (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_q   <= kbd_pkg::port_id_t'(PORTS - 1);          // Port 0 goes first
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (grant_valid) begin
                last_q <= grant_id;
            end
            if (grant_valid && full) begin
                overflow <= 1'b1;                                // Sticky loss flag
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_code[wr_ptr] <= code_vec[grant_id];
            mem_port[wr_ptr] <= grant_id;
        end
    end

    function automatic kbd_pkg::ascii_t to_ascii(input kbd_pkg::scan_code_t sc);
        kbd_pkg::ascii_t ch;
        case (sc)
            8'h1C: ch = 8'h41;   // A
            8'h32: ch = 8'h42;
            8'h21: ch = 8'h43;
            8'h23: ch = 8'h44;
            8'h24: ch = 8'h45;   // E
            8'h2B: ch = 8'h46;
            8'h34: ch = 8'h47;
            8'h33: ch = 8'h48;
            8'h43: ch = 8'h49;
            8'h3B: ch = 8'h4A;   // J
            8'h42: ch = 8'h4B;
            8'h4B: ch = 8'h4C;
            8'h3A: ch = 8'h4D;
            8'h31: ch = 8'h4E;
            8'h44: ch = 8'h4F;   // O
            8'h4D: ch = 8'h50;
            8'h15: ch = 8'h51;
            8'h2D: ch = 8'h52;
            8'h1B: ch = 8'h53;
            8'h2C: ch = 8'h54;   // T
            8'h3C: ch = 8'h55;
            8'h2A: ch = 8'h56;
            8'h1D: ch = 8'h57;
            8'h22: ch = 8'h58;
            8'h35: ch = 8'h59;
            8'h1A: ch = 8'h5A;   // Z
            8'h45: ch = 8'h30;   // Digit 0
            8'h16: ch = 8'h31;
            8'h1E: ch = 8'h32;
            8'h26: ch = 8'h33;
            8'h25: ch = 8'h34;
            8'h2E: ch = 8'h35;
            8'h36: ch = 8'h36;
            8'h3D: ch = 8'h37;
            8'h3E: ch = 8'h38;
            8'h46: ch = 8'h39;   // Digit 9
            default: ch = 8'h00; // F0, E0 and the rest
        endcase
        return ch;
    endfunction

    // Head entry shown combinationally
    assign data  = mem_code[rd_ptr];
    assign port  = mem_port[rd_ptr];
    assign ascii = ready ? to_ascii(data) : 8'h00;               // Stale head never translated

endmodule

// File: tb.f
+incdir+src
src/kbd_pkg.sv
src/ps2_rx_if.sv
src/ps2_sync.sv
src/ps2_frame_rx.sv
src/scan_merge.sv
src/kbd_hub.sv
bench/clk_gen.sv
bench/kbd_hub_assertions.sv
bench/kbd_hub_tb.sv
